// ==== Bender.yml ====
package:
  name: fetch_front

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/fetch_pkg.sv
      - hdl/imem_rom.sv
      - hdl/fetch_buffer.sv
      - hdl/fetch_stage.sv
      - hdl/fetch_top.sv
  - target: test
    files:
      - verif/fetch_tb.sv

// ==== fetch_front.f ====
hdl/core_pkg.sv
hdl/fetch_pkg.sv
hdl/imem_rom.sv
hdl/fetch_buffer.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
verif/fetch_tb.sv

// ==== hdl/core_pkg.sv ====
package core_pkg;

  // data path and address width of the core.
  localparam int xlen = 32;

  // first instruction fetched after reset.
  localparam logic [xlen-1:0] reset_vector = 32'h0000_0100;

  // instruction memory size in words.
  localparam int rom_words = 1024;
  localparam int rom_index_bits = $clog2(rom_words);

  // each rom word is its own byte address xor this pattern.
  localparam logic [xlen-1:0] rom_pattern = 32'h5a3c_0f96;

  // depth of the queue between memory and decode.
  localparam int buffer_depth = 4;
  localparam int buffer_ptr_bits = $clog2(buffer_depth);

endpackage

// ==== hdl/fetch_buffer.sv ====
`timescale 1ns/1ps

module fetch_buffer
  import core_pkg::*, fetch_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  buffer_in_t  buffer_in,
  output buffer_out_t buffer_out
);

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
  } entry_t;

  entry_t entries [buffer_depth];

  logic [buffer_ptr_bits-1:0] wr_ptr;
  logic [buffer_ptr_bits-1:0] rd_ptr;
  logic [buffer_ptr_bits:0]   count;
  logic                       full;
  logic                       empty;
  logic                       push;
  logic                       pop;

  function automatic logic [buffer_ptr_bits-1:0] next_ptr(
    input logic [buffer_ptr_bits-1:0] ptr
  );
    if (ptr == buffer_ptr_bits'(buffer_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full = (count == (buffer_ptr_bits + 1)'(buffer_depth));
  assign empty = (count == '0);

  // a clear wins over both the push and the pop of the same cycle.
  assign push = buffer_in.ready & ~buffer_in.clear & ~full;
  assign pop = ~empty & ~buffer_in.stall & ~buffer_in.clear;

  always_ff @(posedge clock) begin
    if (push) begin
      entries[wr_ptr] <= '{pc: buffer_in.pc, instr: buffer_in.rdata};
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || buffer_in.clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: begin
        end
      endcase
    end
  end

  // the head entry is presented until decode takes it.
  always_comb begin
    buffer_out.pc = entries[rd_ptr].pc;
    buffer_out.instr = entries[rd_ptr].instr;
    buffer_out.done = ~empty;
    buffer_out.stall = full;
  end

  // fetch has to hold back a returning word while the queue is full.
  assert property (@(posedge clock) disable iff (!reset)
    !(buffer_in.ready && full && !buffer_in.clear))
    else $error("fetch_buffer: push into a full queue");

  assert property (@(posedge clock) disable iff (!reset)
    count <= (buffer_ptr_bits + 1)'(buffer_depth))
    else $error("fetch_buffer: count above queue depth");

endmodule

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

  import core_pkg::*;

  typedef enum logic [1:0] {
    idle = 2'd0,
    busy = 2'd1,
    ctrl = 2'd2,
    inv  = 2'd3
  } fetch_state_t;

  typedef struct packed {
    logic            mem_valid;
    logic            mem_fence;
    logic            mem_spec;
    logic [xlen-1:0] mem_addr;
  } mem_in_t;

  typedef struct packed {
    logic            mem_ready;
    logic [xlen-1:0] mem_rdata;
  } mem_out_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rdata;
    logic            ready;
    logic            clear;
    logic            stall;
  } buffer_in_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    logic            done;
    logic            stall;
  } buffer_out_t;

  // only one event at a time takes effect, see fetch_stage for the order.
  typedef struct packed {
    logic            trap;
    logic            mret;
    logic            jump;
    logic            fence;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] target;
    logic [xlen-1:0] npc;
  } redirect_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    logic            done;
  } fetch_out_t;

  typedef struct packed {
    fetch_state_t    state;
    logic [xlen-1:0] addr;
    logic            valid;
    logic            ready;
    logic            stall;
    logic            fence;
    logic            spec;
  } fetch_reg_t;

  // the address sits one word below the reset vector so that idle steps onto it.
  localparam fetch_reg_t fetch_reg_init = '{
    state: idle,
    addr:  reset_vector - 32'd4,
    valid: 1'b0,
    ready: 1'b0,
    stall: 1'b0,
    fence: 1'b0,
    spec:  1'b0
  };

endpackage

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
  import core_pkg::*, fetch_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  redirect_t   redirect,
  input  logic        hold,
  input  mem_out_t    imem_out,
  output mem_in_t     imem_in,
  input  buffer_out_t buffer_out,
  output buffer_in_t  buffer_in,
  output fetch_out_t  fetch_out
);

  fetch_reg_t r;
  fetch_reg_t rin;
  fetch_reg_t v;

  always_comb begin
    v = r;

    v.valid = 1'b0;
    v.fence = 1'b0;
    v.spec = 1'b0;
    v.ready = imem_out.mem_ready;
    v.stall = buffer_out.stall;

    // the address only moves on once the outstanding word has come back.
    case (r.state)
      busy: begin
        if (!v.ready) begin
          v.stall = 1'b1;
        end
      end
      ctrl, inv: begin
        v.stall = 1'b1;
      end
      default: begin
      end
    endcase

    if (redirect.trap) begin
      v.spec = 1'b1;
      v.addr = redirect.mtvec;
    end else if (redirect.mret) begin
      v.spec = 1'b1;
      v.addr = redirect.mepc;
    end else if (redirect.jump) begin
      v.spec = 1'b1;
      v.addr = redirect.target;
    end else if (redirect.fence) begin
      v.fence = 1'b1;
      v.spec = 1'b1;
      v.addr = redirect.npc;
    end else if (!v.stall) begin
      v.addr = v.addr + xlen'(4);
    end

    case (r.state)
      idle: begin
        v.state = busy;
        v.valid = 1'b1;
      end
      busy: begin
        if (v.ready) begin
          v.state = busy;
          v.valid = 1'b1;
          // a full queue cannot take the word, so the same address is asked for again.
          if (buffer_out.stall) begin
            v.ready = 1'b0;
          end
        end else if (v.fence) begin
          v.state = inv;
        end else if (v.spec) begin
          v.state = ctrl;
        end
      end
      default: begin
        // the answer to the old path is dropped and the new target is requested.
        if (v.ready) begin
          v.state = busy;
          v.valid = 1'b1;
        end
        v.ready = 1'b0;
      end
    endcase

    rin = v;

    buffer_in.pc = {r.addr[xlen-1:2], 2'b00};
    buffer_in.rdata = imem_out.mem_rdata;
    buffer_in.ready = v.ready;
    buffer_in.clear = v.spec;
    buffer_in.stall = hold;

    imem_in.mem_valid = v.valid;
    imem_in.mem_fence = v.fence;
    imem_in.mem_spec = v.spec;
    imem_in.mem_addr = v.addr;

    fetch_out.pc = buffer_out.pc;
    fetch_out.instr = buffer_out.instr;
    fetch_out.done = buffer_out.done;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r <= fetch_reg_init;
    end else begin
      r <= rin;
    end
  end

  // leaving busy for a new target while a word is still outstanding must wait in ctrl or inv.
  assert property (@(posedge clock) disable iff (!reset)
    (r.state == busy && imem_in.mem_spec && imem_in.mem_valid) |-> imem_out.mem_ready)
    else $error("fetch_stage: redirect request issued over an outstanding word");

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
  import fetch_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  redirect_t  redirect,
  input  logic       hold,
  input  logic       imem_wait,
  output fetch_out_t fetch_out
);

  mem_in_t     imem_in;
  mem_out_t    imem_out;
  buffer_in_t  buffer_in;
  buffer_out_t buffer_out;

  fetch_stage fetch_stage_i (
    .clock      (clock),
    .reset      (reset),
    .redirect   (redirect),
    .hold       (hold),
    .imem_out   (imem_out),
    .imem_in    (imem_in),
    .buffer_out (buffer_out),
    .buffer_in  (buffer_in),
    .fetch_out  (fetch_out)
  );

  fetch_buffer fetch_buffer_i (
    .clock      (clock),
    .reset      (reset),
    .buffer_in  (buffer_in),
    .buffer_out (buffer_out)
  );

  imem_rom imem_rom_i (
    .clock     (clock),
    .reset     (reset),
    .imem_wait (imem_wait),
    .imem_in   (imem_in),
    .imem_out  (imem_out)
  );

endmodule

// ==== hdl/imem_rom.sv ====
`timescale 1ns/1ps

module imem_rom
  import core_pkg::*, fetch_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     imem_wait,
  input  mem_in_t  imem_in,
  output mem_out_t imem_out
);

  logic                      pending;
  logic [rom_index_bits-1:0] word_index;

  // a new request replaces whatever is still waiting.
  always_ff @(posedge clock) begin
    if (!reset) begin
      pending <= 1'b0;
    end else if (imem_in.mem_valid) begin
      pending <= 1'b1;
    end else if (!imem_wait) begin
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (imem_in.mem_valid) begin
      word_index <= imem_in.mem_addr[rom_index_bits+1:2];
    end
  end

  // contents follow the address, wrapped to the size of the memory.
  always_comb begin
    imem_out.mem_ready = pending & ~imem_wait;
    imem_out.mem_rdata = {{(xlen - rom_index_bits - 2){1'b0}}, word_index, 2'b00} ^ rom_pattern;
  end

  assert property (@(posedge clock) disable iff (!reset)
    imem_in.mem_valid |-> (imem_in.mem_addr[1:0] == 2'b00))
    else $error("imem_rom: unaligned fetch address");

  // a fence always arrives as part of a redirect.
  assert property (@(posedge clock) disable iff (!reset)
    (imem_in.mem_valid && imem_in.mem_fence) |-> imem_in.mem_spec)
    else $error("imem_rom: fence request without spec");

endmodule

// ==== verif/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb
  import core_pkg::*, fetch_pkg::*;
();

  typedef struct {
    string           name;
    int              cycles;
    logic [15:0]     hold_pattern;
    int              wait_density;
    logic [3:0]      kinds;
    logic [xlen-1:0] base;
  } row_t;

  logic       clock;
  logic       reset;
  redirect_t  redirect;
  logic       hold;
  logic       imem_wait;
  fetch_out_t fetch_out;

  row_t            rows[$];
  logic [15:0]     lfsr_state = 16'd28;
  longint          limit_ns = 0;
  int              total_cycles;
  int              errors;
  int              accepted;
  logic [xlen-1:0] expected_pc;
  fetch_out_t      cur_out;
  fetch_out_t      prev_out;
  fetch_out_t      expected;
  logic            prev_hold;
  logic            prev_redirect;
  logic            hold_v;
  logic            redirect_v;
  redirect_t       event_r;
  logic [3:0]      bits;

  fetch_top uut (
    .clock     (clock),
    .reset     (reset),
    .redirect  (redirect),
    .hold      (hold),
    .imem_wait (imem_wait),
    .fetch_out (fetch_out)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // taps 16, 14, 13 and 11, shifting towards bit 0.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
  endfunction

  task automatic draw_bits(input int n, output logic [3:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // the rom word at a byte address is that address xor the pattern, wrapped to the rom.
  function automatic logic [xlen-1:0] rom_word(input logic [xlen-1:0] addr);
    return (addr & xlen'(rom_words * 4 - 1)) ^ rom_pattern;
  endfunction

  function automatic redirect_t make_redirect(input logic [3:0] kinds,
                                              input logic [xlen-1:0] base);
    redirect_t r;
    r = '0;
    {r.trap, r.mret, r.jump, r.fence} = kinds;
    r.mtvec = base;
    r.mepc = base + 32'h100;
    r.target = base + 32'h200;
    r.npc = base + 32'h300;
    return r;
  endfunction

  function automatic logic [xlen-1:0] redirect_address(input redirect_t r);
    if (r.trap) begin
      return r.mtvec;
    end else if (r.mret) begin
      return r.mepc;
    end else if (r.jump) begin
      return r.target;
    end
    return r.npc;
  endfunction

  task automatic add_row(input string name, input int cycles, input logic [15:0] hold_pattern,
                         input int wait_density, input logic [3:0] kinds,
                         input logic [xlen-1:0] base);
    row_t row;
    row.name = name;
    row.cycles = cycles;
    row.hold_pattern = hold_pattern;
    row.wait_density = wait_density;
    row.kinds = kinds;
    row.base = base;
    rows.push_back(row);
  endtask

  task automatic check_fetch(input string name, input fetch_out_t exp, input fetch_out_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected pc %h instr %h done %b, actual pc %h instr %h done %b",
               name, exp.pc, exp.instr, exp.done, act.pc, act.instr, act.done);
    end
  endtask

  task automatic check_hold(input string name, input fetch_out_t exp, input fetch_out_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: held expected pc %h instr %h done %b, actual pc %h instr %h done %b",
               name, exp.pc, exp.instr, exp.done, act.pc, act.instr, act.done);
    end
  endtask

  task automatic check_reset(input string name, input fetch_out_t act);
    if (act.done !== 1'b0) begin
      errors++;
      $display("FAIL %s: expected done 0, actual done %b", name, act.done);
    end
  endtask

  // kinds are {trap, mret, jump, fence}; a redirect is raised on the first cycle of its row.
  task automatic build_table();
    add_row("reset_stream",    16, 16'h0000,  0, 4'b0000, 32'h0);
    add_row("random_wait",     40, 16'h0000,  6, 4'b0000, 32'h0);
    add_row("hold_short",      24, 16'h0f0c,  0, 4'b0000, 32'h0);
    add_row("hold_fill",       20, 16'hffff,  0, 4'b0000, 32'h0);
    add_row("jump_when_full",  14, 16'h0000,  0, 4'b0010, 32'h0a0);
    add_row("hold_random",     32, 16'h3c71,  8, 4'b0000, 32'h0);
    add_row("trap",            14, 16'h0000,  4, 4'b1000, 32'h040);
    add_row("mret",            14, 16'h0003,  4, 4'b0100, 32'h400);
    add_row("jump",            14, 16'h0000,  0, 4'b0010, 32'h080);
    add_row("fence",           14, 16'h0000,  6, 4'b0001, 32'h600);
    add_row("trap_over_all",   14, 16'h0000,  0, 4'b1111, 32'h200);
    add_row("mret_over_jump",  14, 16'h0001, 10, 4'b0111, 32'h800);
    add_row("jump_over_fence", 14, 16'h0000,  5, 4'b0011, 32'h300);
    add_row("fence_in_hold",   20, 16'h000f,  3, 4'b0001, 32'h700);
    add_row("final_drain",     16, 16'h0000,  0, 4'b0000, 32'h0);
  endtask

  initial begin
    wait (limit_ns != 0);
    #(limit_ns);
    $display("watchdog: the run did not end within %0d ns and was stopped", limit_ns);
    $display("sim failed");
    $finish;
  end

  initial begin
    reset = 1'b0;
    hold = 1'b0;
    imem_wait = 1'b0;
    redirect = '0;
    errors = 0;
    accepted = 0;
    expected_pc = reset_vector;
    prev_out = '0;
    prev_hold = 1'b0;
    prev_redirect = 1'b0;

    build_table();
    total_cycles = 0;
    foreach (rows[i]) begin
      total_cycles += rows[i].cycles;
    end
    limit_ns = longint'(4 + total_cycles + 64) * 4;

    for (int i = 0; i < 4; i++) begin
      @(negedge clock);
      cur_out = fetch_out;
      check_reset("reset", cur_out);
    end
    reset = 1'b1;

    // outputs are registered, so the value read at the falling edge belongs to this cycle.
    for (int r = 0; r < rows.size(); r++) begin
      for (int c = 0; c < rows[r].cycles; c++) begin
        @(negedge clock);
        cur_out = fetch_out;
        // a held head is still the next instruction the model expects.
        if (prev_hold && prev_out.done && !prev_redirect) begin
          expected = '{pc: expected_pc, instr: rom_word(expected_pc), done: 1'b1};
          check_hold(rows[r].name, expected, cur_out);
        end
        if ($isunknown(cur_out.done)) begin
          errors++;
          $display("%s: fetch_out.done is unknown after reset", rows[r].name);
        end

        hold_v = rows[r].hold_pattern[c % 16];
        draw_bits(4, bits);
        redirect_v = (c == 0) && (rows[r].kinds != 4'b0000);
        event_r = redirect_v ? make_redirect(rows[r].kinds, rows[r].base) : '0;
        hold = hold_v;
        imem_wait = int'(bits) < rows[r].wait_density;
        redirect = event_r;

        // a redirect flushes the queue, so the head shown in that cycle is not taken.
        if (redirect_v) begin
          expected_pc = redirect_address(event_r);
        end else if (cur_out.done && !hold_v) begin
          expected = '{pc: expected_pc, instr: rom_word(expected_pc), done: 1'b1};
          check_fetch(rows[r].name, expected, cur_out);
          expected_pc = expected_pc + 32'd4;
          accepted++;
        end

        prev_out = cur_out;
        prev_hold = hold_v;
        prev_redirect = redirect_v;
      end
    end

    @(negedge clock);
    hold = 1'b0;
    imem_wait = 1'b0;
    redirect = '0;
    if (accepted < total_cycles / 4) begin
      errors++;
      $display("only %0d instructions were accepted in %0d cycles", accepted, total_cycles);
    end

    $display("fetch_tb: %0d errors, %0d instructions accepted", errors, accepted);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
